//--- logic/adc_capture_defs.svh
`ifndef ADC_CAPTURE_DEFS_SVH
`define ADC_CAPTURE_DEFS_SVH

// Bits per audio sample, MSB first on the wire
`define ADC_SAMPLE_BITS 24

// Bit clocks in one half frame (one LRCK phase)
`define ADC_SLOT_BITS 32

// Serial data lanes from the ADCs
`define ADC_LANES 4

// Channels carried in eight-channel mode
`define ADC_MAX_CHANNELS 8

// Width of a channel index
`define ADC_CHAN_BITS 3

// Sample FIFO holds 2**4 = 16 words
`define FIFO_DEPTH_LOG2 4

`endif

//--- logic/adc_capture_pkg.sv
`include "adc_capture_defs.svh"

package adc_capture_pkg;

    // Serial justification of the ADC data lanes
    typedef enum logic [1:0] {
        FMT_RJ  = 2'b00,
        FMT_LJ  = 2'b01,
        FMT_I2S = 2'b10
    } adc_format_e;

    // Capture settings, sampled once per frame
    typedef struct packed {
        adc_format_e format;
        // 1 selects eight channels on four lanes, 0 two channels on lane 0
        logic        eight_chan;
    } capture_cfg_t;

    // One captured sample tagged with its channel
    typedef struct packed {
        logic [`ADC_CHAN_BITS-1:0]   channel;
        logic [`ADC_SAMPLE_BITS-1:0] sample;
    } sample_word_t;

endpackage

//--- logic/i2s_deserializer.sv
`timescale 1ns/10ps

`include "adc_capture_defs.svh"

module i2s_deserializer
    import adc_capture_pkg::*;
(
    input  logic                  adc_pbck,
    input  logic                  sclk,
    input  logic                  adc_plrck,
    input  logic [`ADC_LANES-1:0] adc_pdata,
    input  capture_cfg_t          cfg,
    input  logic                  record_en,
    output logic                  wr_en,
    output sample_word_t          wr_word
);

    localparam int POS_BITS = $clog2(`ADC_SLOT_BITS);

    logic                        plrck_d;
    logic [POS_BITS-1:0]         pos_cnt;
    logic [POS_BITS-1:0]         cur_pos;
    logic                        lr_edge;
    logic                        frame_start;
    capture_cfg_t                cfg_lat;
    logic                        rec_lat;
    adc_format_e                 act_fmt;
    logic                        in_window;

    // Shift registers for the half frames in progress
    logic [`ADC_SAMPLE_BITS-1:0] shift_l [`ADC_LANES];
    logic [`ADC_SAMPLE_BITS-1:0] shift_r [`ADC_LANES];

    // Completed frame, drained while the next one is shifted in
    logic [`ADC_SAMPLE_BITS-1:0] bank_l [`ADC_LANES];
    logic [`ADC_SAMPLE_BITS-1:0] bank_r [`ADC_LANES];

    logic                        emitting;
    logic                        emit_eight;
    logic [`ADC_CHAN_BITS-1:0]   emit_idx;
    logic [`ADC_CHAN_BITS-1:0]   last_idx;
    logic [`ADC_CHAN_BITS-2:0]   emit_lane;

    // Any LRCK change starts a half frame at position 0
    assign lr_edge     = (adc_plrck != plrck_d);
    assign frame_start = lr_edge && !adc_plrck;
    assign cur_pos     = lr_edge ? '0 : pos_cnt;

    // The new frame's format already applies at its first bit clock
    assign act_fmt = frame_start ? cfg.format : cfg_lat.format;

    always_comb begin
        case (act_fmt)
            FMT_I2S: in_window = (cur_pos >= 1) && (cur_pos <= `ADC_SAMPLE_BITS);
            FMT_LJ:  in_window = (cur_pos < `ADC_SAMPLE_BITS);
            FMT_RJ:  in_window = (cur_pos >= (`ADC_SLOT_BITS - `ADC_SAMPLE_BITS));
            default: in_window = 1'b0;
        endcase
    end

    always_ff @(posedge adc_pbck) begin
        for (int i = 0; i < `ADC_LANES; i++) begin
            if (in_window && !adc_plrck)
                shift_l[i] <= {shift_l[i][`ADC_SAMPLE_BITS-2:0], adc_pdata[i]};
            if (in_window && adc_plrck)
                shift_r[i] <= {shift_r[i][`ADC_SAMPLE_BITS-2:0], adc_pdata[i]};
        end

        // Right half has just finished, so both registers hold a full frame
        if (frame_start && rec_lat) begin
            for (int i = 0; i < `ADC_LANES; i++) begin
                bank_l[i] <= shift_l[i];
                bank_r[i] <= shift_r[i];
            end
        end
    end

    always_ff @(posedge adc_pbck or posedge sclk) begin
        if (sclk) begin
            plrck_d    <= 1'b0;
            pos_cnt    <= '0;
            cfg_lat    <= '0;
            rec_lat    <= 1'b0;
            emitting   <= 1'b0;
            emit_eight <= 1'b0;
            emit_idx   <= '0;
        end else begin
            plrck_d <= adc_plrck;
            pos_cnt <= cur_pos + 1'b1;

            if (frame_start) begin
                cfg_lat <= cfg;
                rec_lat <= record_en;
                // Frame that just ended is sent only if it was armed at its start
                if (rec_lat) begin
                    emitting   <= 1'b1;
                    emit_eight <= cfg_lat.eight_chan;
                    emit_idx   <= '0;
                end
            end else if (emitting) begin
                if (emit_idx == last_idx)
                    emitting <= 1'b0;
                emit_idx <= emit_idx + 1'b1;
            end
        end
    end

    assign last_idx = emit_eight ? `ADC_CHAN_BITS'(`ADC_MAX_CHANNELS - 1)
                                 : `ADC_CHAN_BITS'(1);

    // Even channels are left samples, odd channels right, two per lane
    assign emit_lane       = emit_idx[`ADC_CHAN_BITS-1:1];
    assign wr_en           = emitting;
    assign wr_word.channel = emit_idx;
    assign wr_word.sample  = emit_idx[0] ? bank_r[emit_lane] : bank_l[emit_lane];

endmodule

//--- logic/sample_fifo.sv
`timescale 1ns/10ps

`include "adc_capture_defs.svh"

module sample_fifo
    import adc_capture_pkg::*;
#(
    parameter int depth_log2 = `FIFO_DEPTH_LOG2
) (
    input  logic         adc_pbck,
    input  logic         sclk,
    input  logic         wr_en,
    input  sample_word_t wr_word,
    input  logic         rd_en,
    output sample_word_t rd_data,
    output logic         empty,
    output logic         overflow
);

    localparam int DEPTH = 1 << depth_log2;

    sample_word_t          mem [DEPTH];
    logic [depth_log2-1:0] wr_ptr;
    logic [depth_log2-1:0] rd_ptr;
    logic [depth_log2:0]   count;
    logic                  full;
    logic                  do_rd;
    logic                  do_wr;

    assign empty = (count == '0);
    assign full  = (count == (depth_log2 + 1)'(DEPTH));

    // A pop in the same cycle frees the slot for a write on a full FIFO
    assign do_rd = rd_en && !empty;
    assign do_wr = wr_en && (!full || do_rd);

    // First-word fall-through read port
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge adc_pbck) begin
        if (do_wr)
            mem[wr_ptr] <= wr_word;
    end

    always_ff @(posedge adc_pbck or posedge sclk) begin
        if (sclk) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;

            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;

            // Sticky until reset; the dropped word is lost
            if (wr_en && !do_wr)
                overflow <= 1'b1;
        end
    end

endmodule

//--- logic/host_word_sender.sv
`timescale 1ns/10ps

`include "adc_capture_defs.svh"

module host_word_sender
    import adc_capture_pkg::*;
(
    input  logic         adc_pbck,
    input  logic         sclk,
    input  sample_word_t rd_data,
    input  logic         empty,
    output logic         rd_en,
    output logic         host_req,
    input  logic         host_ack,
    output sample_word_t host_word
);

    typedef enum logic [1:0] {
        S_IDLE     = 2'b00,
        S_REQ      = 2'b01,
        S_ACK_WAIT = 2'b10
    } send_state_e;

    send_state_e state;

    // Pop only when the previous handshake has fully returned to zero
    assign rd_en    = (state == S_IDLE) && !empty && !host_ack;
    assign host_req = (state == S_REQ);

    // Word is held from the pop until the next pop
    always_ff @(posedge adc_pbck) begin
        if (rd_en)
            host_word <= rd_data;
    end

    always_ff @(posedge adc_pbck or posedge sclk) begin
        if (sclk) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (rd_en)
                        state <= S_REQ;
                end
                S_REQ: begin
                    // Host has taken the word
                    if (host_ack)
                        state <= S_ACK_WAIT;
                end
                S_ACK_WAIT: begin
                    if (!host_ack)
                        state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/adc_capture_top.sv
`timescale 1ns/10ps

`include "adc_capture_defs.svh"

module adc_capture_top
    import adc_capture_pkg::*;
(
    input  logic                  adc_pbck,
    input  logic                  sclk,
    input  logic                  adc_plrck,
    input  logic [`ADC_LANES-1:0] adc_pdata,
    input  capture_cfg_t          cfg,
    input  logic                  record_en,
    output logic                  host_req,
    input  logic                  host_ack,
    output sample_word_t          host_word,
    output logic                  overflow
);

    // Producer side of the sample FIFO
    logic         wr_en;
    sample_word_t wr_word;

    // Consumer side of the sample FIFO
    logic         rd_en;
    sample_word_t rd_data;
    logic         empty;

    i2s_deserializer u_deser (
        .adc_pbck  (adc_pbck),
        .sclk      (sclk),
        .adc_plrck (adc_plrck),
        .adc_pdata (adc_pdata),
        .cfg       (cfg),
        .record_en (record_en),
        .wr_en     (wr_en),
        .wr_word   (wr_word)
    );

    sample_fifo #(.depth_log2(`FIFO_DEPTH_LOG2)) u_fifo (
        .adc_pbck (adc_pbck),
        .sclk     (sclk),
        .wr_en    (wr_en),
        .wr_word  (wr_word),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .empty    (empty),
        .overflow (overflow)
    );

    host_word_sender u_sender (
        .adc_pbck  (adc_pbck),
        .sclk      (sclk),
        .rd_data   (rd_data),
        .empty     (empty),
        .rd_en     (rd_en),
        .host_req  (host_req),
        .host_ack  (host_ack),
        .host_word (host_word)
    );

endmodule

//--- testbench/adc_capture_assertions.sv
`timescale 1ns/10ps

module adc_capture_assertions
    import adc_capture_pkg::*;
(
    input logic         adc_pbck,
    input logic         sclk,
    input logic         host_req,
    input logic         host_ack,
    input sample_word_t host_word
);

    // Req is withdrawn only once the host has acked
    req_after_ack: assert property (
        @(posedge adc_pbck) disable iff (sclk)
        $fell(host_req) |-> $past(host_ack)
    ) else $error("host_req fell while host_ack was low");

    // Word is loaded at the pop and must hold for the whole request
    word_stable: assert property (
        @(posedge adc_pbck) disable iff (sclk)
        host_req && $past(host_req) |-> $stable(host_word)
    ) else $error("host_word changed while host_req was high");

    // New request only once the previous ack has returned low
    req_after_release: assert property (
        @(posedge adc_pbck) disable iff (sclk)
        $rose(host_req) |-> !$past(host_ack)
    ) else $error("host_req rose while host_ack was still high");

endmodule

bind host_word_sender adc_capture_assertions u_handshake_checks (.*);

//--- testbench/tb_adc_capture.sv
`timescale 1ns/10ps

`include "adc_capture_defs.svh"

module tb_adc_capture
    import adc_capture_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int DRIVE_DLY    = 1;
    localparam int SAMPLE_DLY   = 2;
    localparam int WAIT_DLY     = 3;
    localparam int FRAME_CYCLES = 2 * `ADC_SLOT_BITS;
    localparam int FIFO_WORDS   = 1 << `FIFO_DEPTH_LOG2;
    localparam int unsigned SEED = 32'h8c75;

    // Frames per test section
    localparam int N_I2S   = 4;
    localparam int N_LJRJ  = 4;
    localparam int N_EIGHT = 3;
    localparam int N_GATE  = 8;
    localparam int N_SLOW  = 6;
    localparam int N_HOLD  = 3;
    localparam int N_FRAMES = N_I2S + N_LJRJ + N_EIGHT + N_GATE + N_SLOW + N_HOLD + 2;
    localparam int WATCHDOG_NS = N_FRAMES * FRAME_CYCLES * CLK_PERIOD * 4 + 20000;

    logic                  adc_pbck;
    logic                  sclk;
    logic                  adc_plrck;
    logic [`ADC_LANES-1:0] adc_pdata;
    capture_cfg_t          cfg;
    logic                  record_en;
    logic                  host_req;
    logic                  host_ack;
    sample_word_t          host_word;
    logic                  overflow;

    sample_word_t exp_q [$];
    int           max_ack_delay;
    logic         hold_ack;
    int           words_seen;

    always #(CLK_PERIOD / 2) adc_pbck = ~adc_pbck;

    adc_capture_top UUT (
        .adc_pbck  (adc_pbck),
        .sclk      (sclk),
        .adc_plrck (adc_plrck),
        .adc_pdata (adc_pdata),
        .cfg       (cfg),
        .record_en (record_en),
        .host_req  (host_req),
        .host_ack  (host_ack),
        .host_word (host_word),
        .overflow  (overflow)
    );

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    // Channel 2k is the left sample of lane k, 2k+1 the right one
    function automatic int expected_frame(
        input  logic [`ADC_MAX_CHANNELS-1:0][`ADC_SAMPLE_BITS-1:0] samp,
        input  capture_cfg_t                                     c,
        input  logic                                             rec,
        output sample_word_t [`ADC_MAX_CHANNELS-1:0]             words
    );
        int lanes;
        int n;
        words = '0;
        n = 0;
        if (!rec)
            return 0;
        lanes = c.eight_chan ? `ADC_LANES : 1;
        for (int lane = 0; lane < lanes; lane++) begin
            for (int half = 0; half < 2; half++) begin
                words[n].channel = `ADC_CHAN_BITS'(2 * lane + half);
                words[n].sample  = samp[2 * lane + half];
                n++;
            end
        end
        return n;
    endfunction

    // Bit on the wire at one half-frame position, MSB first
    function automatic logic serial_bit(input adc_format_e fmt, input int pos,
                                        input logic [`ADC_SAMPLE_BITS-1:0] s);
        int msb_pos;
        int idx;
        case (fmt)
            FMT_I2S: msb_pos = 1;
            FMT_LJ:  msb_pos = 0;
            default: msb_pos = `ADC_SLOT_BITS - `ADC_SAMPLE_BITS;
        endcase
        idx = pos - msb_pos;
        if (idx >= 0 && idx < `ADC_SAMPLE_BITS)
            return s[`ADC_SAMPLE_BITS - 1 - idx];
        else
            return 1'($urandom());
    endfunction

    task automatic play_frame(input capture_cfg_t c, input logic rec);
        logic [`ADC_MAX_CHANNELS-1:0][`ADC_SAMPLE_BITS-1:0] samp;
        sample_word_t [`ADC_MAX_CHANNELS-1:0]             words;
        int                                               n;
        for (int i = 0; i < `ADC_MAX_CHANNELS; i++)
            samp[i] = `ADC_SAMPLE_BITS'($urandom());
        n = expected_frame(samp, c, rec, words);
        for (int i = 0; i < n; i++)
            exp_q.push_back(words[i]);
        for (int half = 0; half < 2; half++) begin
            for (int pos = 0; pos < `ADC_SLOT_BITS; pos++) begin
                @(posedge adc_pbck);
                #DRIVE_DLY;
                // Settings are latched at the first left-half bit clock
                if (half == 0 && pos == 0) begin
                    cfg       = c;
                    record_en = rec;
                end
                adc_plrck = 1'(half);
                for (int lane = 0; lane < `ADC_LANES; lane++)
                    adc_pdata[lane] = serial_bit(c.format, pos, samp[2 * lane + half]);
            end
        end
    endtask

    task automatic wait_drain();
        do begin
            @(posedge adc_pbck);
            #WAIT_DLY;
        end while (exp_q.size() != 0 || host_req || host_ack);
    endtask

    task automatic wait_words(input int target);
        while (words_seen < target) begin
            @(posedge adc_pbck);
            #WAIT_DLY;
        end
    endtask

    // Host side of the four-phase handshake
    initial begin : host_responder
        int gap;
        forever begin
            @(posedge adc_pbck);
            #DRIVE_DLY;
            if (hold_ack) begin
                host_ack = 1'b1;
            end else if (host_req != host_ack) begin
                gap = $urandom_range(max_ack_delay);
                repeat (gap) begin
                    @(posedge adc_pbck);
                    #DRIVE_DLY;
                end
                host_ack = !host_ack;
            end
        end
    end

    initial begin : compare_words
        logic         req_seen;
        sample_word_t exp_w;
        req_seen = 1'b0;
        forever begin
            @(posedge adc_pbck);
            #SAMPLE_DLY;
            if (host_req && !req_seen) begin
                if (exp_q.size() == 0) begin
                    $display("Host request raised with no word expected at %0t", $time);
                    abort_run();
                end
                exp_w = exp_q.pop_front();
                check_value("host_word.channel", 32'(host_word.channel), 32'(exp_w.channel));
                check_value("host_word.sample", 32'(host_word.sample), 32'(exp_w.sample));
                words_seen++;
            end
            req_seen = host_req;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the test did not complete within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    initial begin : main_sequence
        capture_cfg_t c;
        int           base;
        void'($urandom(SEED));
        adc_pbck      = 1'b0;
        sclk          = 1'b1;
        adc_plrck     = 1'b1;
        adc_pdata     = '0;
        cfg           = '0;
        record_en     = 1'b0;
        host_ack      = 1'b0;
        hold_ack      = 1'b0;
        max_ack_delay = 0;
        words_seen    = 0;
        repeat (5) @(posedge adc_pbck);
        #DRIVE_DLY;
        sclk = 1'b0;

        c.format     = FMT_I2S;
        c.eight_chan = 1'b0;
        repeat (N_I2S) play_frame(c, 1'b1);

        // Justification switched frame by frame
        for (int i = 0; i < N_LJRJ; i++) begin
            c.format = (i % 2 == 0) ? FMT_LJ : FMT_RJ;
            play_frame(c, 1'b1);
        end

        c.format     = FMT_I2S;
        c.eight_chan = 1'b1;
        repeat (N_EIGHT) play_frame(c, 1'b1);

        // Record enable and settings changed at random frame boundaries
        for (int i = 0; i < N_GATE; i++) begin
            c.format     = adc_format_e'(2'($urandom_range(2)));
            c.eight_chan = 1'($urandom());
            play_frame(c, 1'($urandom()));
        end

        // Slow host, every other frame recorded so the FIFO keeps up
        max_ack_delay = 5;
        c.format      = FMT_I2S;
        c.eight_chan  = 1'b1;
        for (int i = 0; i < N_SLOW; i++)
            play_frame(c, 1'(i % 2 == 0));
        play_frame(c, 1'b0);
        wait_drain();
        check_value("overflow", 32'(overflow), 32'h0);

        // Host stalls with ack high until the FIFO has overflowed
        max_ack_delay = 0;
        hold_ack      = 1'b1;
        base          = words_seen;
        repeat (N_HOLD) play_frame(c, 1'b1);
        play_frame(c, 1'b0);
        @(posedge adc_pbck);
        #WAIT_DLY;
        hold_ack = 1'b0;
        wait_words(base + FIFO_WORDS);
        repeat (FRAME_CYCLES) @(posedge adc_pbck);
        #WAIT_DLY;
        check_value("delivered words", 32'(words_seen - base), 32'(FIFO_WORDS));
        check_value("dropped words", 32'(exp_q.size()), 32'(N_HOLD * 8 - FIFO_WORDS));
        repeat (N_HOLD * 8 - FIFO_WORDS) void'(exp_q.pop_back());

        check_value("overflow", 32'(overflow), 32'h1);
        if (exp_q.size() != 0) begin
            $display("Expected words left undelivered: %0d", exp_q.size());
            abort_run();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- tb.f
+incdir+logic
logic/adc_capture_pkg.sv
logic/i2s_deserializer.sv
logic/sample_fifo.sv
logic/host_word_sender.sv
logic/adc_capture_top.sv
testbench/adc_capture_assertions.sv
testbench/tb_adc_capture.sv

//--- run_sim.sh
#!/bin/sh
# Build the ADC capture testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_adc_capture -f tb.f -o tb_adc_capture \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_adc_capture > "$LOG" 2>&1 || echo "Simulator exited with an error status"

cat "$LOG"

grep -q "^Simulation finished: PASS$" "$LOG" && echo "Test passed" \
    || { echo "Test failed, see $LOG"; exit 1; }
